// File: src/axi_pkg.sv
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int ID_W   = 4;
    localparam int STRB_W = DATA_W / 8;
    localparam int OFS_W  = $clog2(STRB_W);     // byte offset bits within a bus word

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [7:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;      // INCR only
    } axi_aw_t;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [7:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0]  data;
        logic [STRB_W-1:0]  strb;
        logic               last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [1:0]         resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [DATA_W-1:0]  data;
        logic [1:0]         resp;
        logic               last;
    } axi_r_t;

endpackage

// File: src/model_pkg.sv
package model_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // path latencies
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int R_DELAY = 25;                    // AR accept to first R valid
    localparam int W_DELAY = 3;                     // last W accept to B valid
    localparam int R_CNT_W = $clog2(R_DELAY + 1);
    localparam int W_CNT_W = $clog2(W_DELAY + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // backing store
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int MEM_WORDS = 1024;
    localparam int IDX_W     = $clog2(MEM_WORDS);

    // reset sequence
    localparam int RST_CYCLES = 4;                  // path clear pulse length
    localparam int RST_CNT_W  = $clog2(RST_CYCLES + 1);

    typedef enum logic [1:0] {
        MODEL_UP    = 2'd0,
        MODEL_DRAIN = 2'd1,
        MODEL_DOWN  = 2'd2
    } model_state_t;

endpackage

// File: src/model_mem.sv
`timescale 1ns/1ps

module model_mem (
    input  logic                            aclk,
    input  logic                            wr_en,
    input  logic [model_pkg::IDX_W-1:0]     wr_idx,
    input  logic [axi_pkg::DATA_W-1:0]      wr_data,
    input  logic [axi_pkg::STRB_W-1:0]      wr_strb,
    input  logic [model_pkg::IDX_W-1:0]     rd_idx,
    output logic [axi_pkg::DATA_W-1:0]      rd_data
);
    import axi_pkg::*;
    import model_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    // byte lanes written only where strobed
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        rd_data <= mem[rd_idx];                     // one cycle read latency
    end

endmodule

// File: src/axi_write_path.sv
`timescale 1ns/1ps

module axi_write_path (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            stall,
    input  logic                            accept_en,
    input  logic                            path_clear,
    input  axi_pkg::axi_aw_t                aw,
    input  logic                            aw_valid,
    output logic                            aw_ready,
    input  axi_pkg::axi_w_t                 w,
    input  logic                            w_valid,
    output logic                            w_ready,
    output axi_pkg::axi_b_t                 b,
    output logic                            b_valid,
    input  logic                            b_ready,
    output logic                            wr_en,
    output logic [model_pkg::IDX_W-1:0]     wr_idx,
    output logic [axi_pkg::DATA_W-1:0]      wr_data,
    output logic [axi_pkg::STRB_W-1:0]      wr_strb,
    output logic                            idle
);
    import axi_pkg::*;
    import model_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_DELAY,
        WR_RESP
    } wr_state_t;

    wr_state_t              state;
    logic [W_CNT_W-1:0]     dly_cnt;
    logic [ID_W-1:0]        id_q;
    logic [IDX_W-1:0]       idx_q;
    logic                   aw_take;
    logic                   w_take;
    logic                   b_take;

    assign idle     = (state == WR_IDLE);
    assign aw_ready = idle && accept_en && !stall;
    assign w_ready  = (state == WR_DATA) && !stall;
    assign b_valid  = (state == WR_RESP);

    assign aw_take  = aw_valid && aw_ready;
    assign w_take   = w_valid && w_ready;
    assign b_take   = b_valid && b_ready && !stall;   // frozen while stalled

    // store write port
    assign wr_en    = w_take;
    assign wr_idx   = idx_q;
    assign wr_data  = w.data;
    assign wr_strb  = w.strb;

    assign b = '{id: id_q, resp: RESP_OKAY};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // burst FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state   <= WR_IDLE;
            dly_cnt <= '0;
        end else if (path_clear) begin
            state   <= WR_IDLE;                     // drop whatever is in flight
            dly_cnt <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_take) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_take && w.last) begin
                        state   <= WR_DELAY;
                        dly_cnt <= W_CNT_W'(W_DELAY - 1);
                    end
                end
                WR_DELAY: begin
                    if (!stall) begin
                        if (dly_cnt == W_CNT_W'(1)) begin
                            state <= WR_RESP;
                        end else begin
                            dly_cnt <= dly_cnt - 1'b1;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_take) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // burst id and word pointer
    always_ff @(posedge aclk) begin
        if (aw_take) begin
            id_q  <= aw.id;
            idx_q <= aw.addr[OFS_W +: IDX_W];
        end else if (w_take) begin
            idx_q <= idx_q + 1'b1;                  // INCR, wraps at store depth
        end
    end

endmodule

// File: src/axi_read_path.sv
`timescale 1ns/1ps

module axi_read_path (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            stall,
    input  logic                            accept_en,
    input  logic                            path_clear,
    input  axi_pkg::axi_ar_t                ar,
    input  logic                            ar_valid,
    output logic                            ar_ready,
    output axi_pkg::axi_r_t                 r,
    output logic                            r_valid,
    input  logic                            r_ready,
    input  logic [axi_pkg::DATA_W-1:0]      rd_data,
    output logic [model_pkg::IDX_W-1:0]     rd_idx,
    output logic                            idle
);
    import axi_pkg::*;
    import model_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_BURST
    } rd_state_t;

    rd_state_t              state;
    logic [R_CNT_W-1:0]     dly_cnt;
    logic [7:0]             beat_cnt;
    logic                   r_hold;
    logic [ID_W-1:0]        id_q;
    logic [7:0]             len_q;
    logic [IDX_W-1:0]       idx_q;
    logic [DATA_W-1:0]      data_q;
    logic                   ar_take;
    logic                   r_take;

    assign idle     = (state == RD_IDLE);
    assign ar_ready = idle && accept_en && !stall;
    assign r_valid  = (state == RD_BURST);

    assign ar_take  = ar_valid && ar_ready;
    assign r_take   = r_valid && r_ready && !stall;

    // look one word ahead when the current beat goes out
    assign rd_idx   = r_take ? idx_q + 1'b1 : idx_q;

    assign r = '{
        id:   id_q,
        data: r_hold ? data_q : rd_data,            // held beat keeps its payload
        resp: RESP_OKAY,
        last: (beat_cnt == len_q)
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // burst FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= RD_IDLE;
            dly_cnt  <= '0;
            beat_cnt <= '0;
        end else if (path_clear) begin
            state    <= RD_IDLE;
            dly_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_take) begin
                        state    <= RD_WAIT;
                        dly_cnt  <= R_CNT_W'(R_DELAY - 1);
                        beat_cnt <= '0;
                    end
                end
                RD_WAIT: begin
                    if (!stall) begin
                        if (dly_cnt == R_CNT_W'(1)) begin
                            state <= RD_BURST;
                        end else begin
                            dly_cnt <= dly_cnt - 1'b1;
                        end
                    end
                end
                RD_BURST: begin
                    if (r_take) begin
                        if (r.last) begin
                            state <= RD_IDLE;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            r_hold <= 1'b0;
        end else begin
            r_hold <= r_valid && !r_take;
        end
    end

    always_ff @(posedge aclk) begin
        data_q <= r.data;
        if (ar_take) begin
            id_q  <= ar.id;
            len_q <= ar.len;
            idx_q <= ar.addr[OFS_W +: IDX_W];
        end else if (r_take) begin
            idx_q <= idx_q + 1'b1;
        end
    end

endmodule

// File: src/model_ctrl.sv
`timescale 1ns/1ps

module model_ctrl (
    input  logic    aclk,
    input  logic    rst_n,
    input  logic    up_req,
    input  logic    down_req,
    input  logic    seq_up_req,
    input  logic    seq_down_req,
    input  logic    seq_clear,
    input  logic    wr_idle,
    input  logic    rd_idle,
    output logic    accept_en,
    output logic    path_clear,
    output logic    up_stat,
    output logic    down_stat
);
    import model_pkg::*;

    model_state_t   state;
    model_state_t   state_nxt;
    logic           up_any;
    logic           down_any;

    assign up_any   = up_req || seq_up_req;         // host and sequencer merged
    assign down_any = down_req || seq_down_req;

    always_comb begin
        state_nxt = state;
        case (state)
            MODEL_UP:    if (down_any) state_nxt = MODEL_DRAIN;
            MODEL_DRAIN: if (wr_idle && rd_idle) state_nxt = MODEL_DOWN;
            MODEL_DOWN:  if (up_any) state_nxt = MODEL_UP;
            default:     state_nxt = MODEL_UP;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state     <= MODEL_UP;
            accept_en <= 1'b0;                      // no bursts during reset
        end else begin
            state     <= state_nxt;
            accept_en <= (state_nxt == MODEL_UP);
        end
    end

    assign up_stat    = (state == MODEL_UP);
    assign down_stat  = (state == MODEL_DOWN);
    assign path_clear = seq_clear;

endmodule

// File: src/rst_down_gen.sv
`timescale 1ns/1ps

module rst_down_gen (
    input  logic    aclk,
    input  logic    rst_n,
    input  logic    dut_rst_n,
    input  logic    down_stat,
    output logic    stall_gen,
    output logic    seq_down_req,
    output logic    seq_up_req,
    output logic    seq_clear
);
    import model_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_DOWN,
        SEQ_CLEAR,
        SEQ_WAIT_RELEASE
    } seq_state_t;

    seq_state_t             state;
    logic [RST_CNT_W-1:0]   clr_cnt;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state        <= SEQ_IDLE;
            clr_cnt      <= '0;
            seq_down_req <= 1'b0;
            seq_up_req   <= 1'b0;
        end else begin
            seq_down_req <= 1'b0;
            seq_up_req   <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (!dut_rst_n && !down_stat) begin
                        state        <= SEQ_WAIT_DOWN;
                        seq_down_req <= 1'b1;
                    end
                end
                SEQ_WAIT_DOWN: begin
                    if (down_stat) begin
                        state   <= SEQ_CLEAR;
                        clr_cnt <= RST_CNT_W'(RST_CYCLES - 1);
                    end
                end
                SEQ_CLEAR: begin
                    if (clr_cnt == '0) begin
                        state <= SEQ_WAIT_RELEASE;
                    end else begin
                        clr_cnt <= clr_cnt - 1'b1;
                    end
                end
                SEQ_WAIT_RELEASE: begin
                    if (dut_rst_n) begin            // device out of reset
                        state      <= SEQ_IDLE;
                        seq_up_req <= 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign stall_gen = (state != SEQ_IDLE);         // whole sequence
    assign seq_clear = (state == SEQ_CLEAR);

endmodule

// File: src/ram_model.sv
`timescale 1ns/1ps

module ram_model (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                dut_rst_n,
    input  axi_pkg::axi_aw_t    aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  axi_pkg::axi_w_t     w,
    input  logic                w_valid,
    output logic                w_ready,
    output axi_pkg::axi_b_t     b,
    output logic                b_valid,
    input  logic                b_ready,
    input  axi_pkg::axi_ar_t    ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output axi_pkg::axi_r_t     r,
    output logic                r_valid,
    input  logic                r_ready,
    input  logic                stall,
    input  logic                up_req,
    input  logic                down_req,
    output logic                up_stat,
    output logic                down_stat,
    output logic                stall_gen
);
    import axi_pkg::*;
    import model_pkg::*;

    logic                   accept_en;
    logic                   path_clear;
    logic                   wr_idle;
    logic                   rd_idle;
    logic                   seq_down_req;
    logic                   seq_up_req;
    logic                   seq_clear;
    logic                   wr_en;
    logic [IDX_W-1:0]       wr_idx;
    logic [DATA_W-1:0]      wr_data;
    logic [STRB_W-1:0]      wr_strb;
    logic [IDX_W-1:0]       rd_idx;
    logic [DATA_W-1:0]      rd_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rst_down_gen u_rst_down_gen (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .dut_rst_n      (dut_rst_n),
        .down_stat      (down_stat),
        .stall_gen      (stall_gen),
        .seq_down_req   (seq_down_req),
        .seq_up_req     (seq_up_req),
        .seq_clear      (seq_clear)
    );

    model_ctrl u_model_ctrl (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .up_req         (up_req),
        .down_req       (down_req),
        .seq_up_req     (seq_up_req),
        .seq_down_req   (seq_down_req),
        .seq_clear      (seq_clear),
        .wr_idle        (wr_idle),
        .rd_idle        (rd_idle),
        .accept_en      (accept_en),
        .path_clear     (path_clear),
        .up_stat        (up_stat),
        .down_stat      (down_stat)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    axi_write_path u_axi_write_path (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .stall          (stall),
        .accept_en      (accept_en),
        .path_clear     (path_clear),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .wr_en          (wr_en),
        .wr_idx         (wr_idx),
        .wr_data        (wr_data),
        .wr_strb        (wr_strb),
        .idle           (wr_idle)
    );

    axi_read_path u_axi_read_path (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .stall          (stall),
        .accept_en      (accept_en),
        .path_clear     (path_clear),
        .ar             (ar),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .r              (r),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .rd_data        (rd_data),
        .rd_idx         (rd_idx),
        .idle           (rd_idle)
    );

    model_mem u_model_mem (
        .aclk           (aclk),
        .wr_en          (wr_en),
        .wr_idx         (wr_idx),
        .wr_data        (wr_data),
        .wr_strb        (wr_strb),
        .rd_idx         (rd_idx),
        .rd_data        (rd_data)
    );

endmodule

// File: sim/tb_ram_model.sv
`timescale 1ns/1ps

module tb_ram_model;
    import axi_pkg::*;
    import model_pkg::*;

    localparam int LIMIT = 200;                     // cycles per wait

    logic               aclk;
    logic               rst_n;
    logic               dut_rst_n;
    axi_aw_t            aw;
    logic               aw_valid;
    logic               aw_ready;
    axi_w_t             w;
    logic               w_valid;
    logic               w_ready;
    axi_b_t             b;
    logic               b_valid;
    logic               b_ready;
    axi_ar_t            ar;
    logic               ar_valid;
    logic               ar_ready;
    axi_r_t             r;
    logic               r_valid;
    logic               r_ready;
    logic               stall;
    logic               up_req;
    logic               down_req;
    logic               up_stat;
    logic               down_stat;
    logic               stall_gen;

    integer             seed;
    logic [DATA_W-1:0]  ref_mem [MEM_WORDS];
    logic [IDX_W-1:0]   wptr;
    logic [IDX_W-1:0]   rptr;
    logic [ID_W-1:0]    exp_bid;
    logic [ID_W-1:0]    exp_rid;
    logic [7:0]         exp_len;
    logic [7:0]         beat;
    logic               wr_act;
    logic               rd_act;
    int                 w_lat;
    logic               w_lat_on;
    int                 r_lat;
    logic               r_lat_on;
    logic [DATA_W-1:0]  exp_data;
    logic               r_take;

    ram_model dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [IDX_W-1:0] word_of(input logic [ADDR_W-1:0] addr);
        return IDX_W'((addr / STRB_W) % MEM_WORDS);
    endfunction

    task automatic tick();
        @(posedge aclk);
        #1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model of the store
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign r_take   = r_valid && r_ready && !stall;
    assign exp_data = ref_mem[rptr];

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_act   <= 1'b0;
            rd_act   <= 1'b0;
            w_lat_on <= 1'b0;
            r_lat_on <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                wptr    <= word_of(aw.addr);
                exp_bid <= aw.id;
                wr_act  <= 1'b1;
            end
            if (w_valid && w_ready) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (w.strb[i]) ref_mem[wptr][8*i +: 8] <= w.data[8*i +: 8];
                end
                wptr <= wptr + 1'b1;
                if (w.last) begin
                    w_lat    <= 1;
                    w_lat_on <= 1'b1;
                end
            end else if (w_lat_on && !b_valid && !stall) begin
                w_lat <= w_lat + 1;                 // unstalled cycles only
            end
            if (b_valid) w_lat_on <= 1'b0;
            if (b_valid && b_ready && !stall) wr_act <= 1'b0;

            if (ar_valid && ar_ready) begin
                rptr     <= word_of(ar.addr);
                exp_rid  <= ar.id;
                exp_len  <= ar.len;
                beat     <= '0;
                rd_act   <= 1'b1;
                r_lat    <= 1;
                r_lat_on <= 1'b1;
            end else if (r_lat_on && !r_valid && !stall) begin
                r_lat <= r_lat + 1;
            end
            if (r_valid) r_lat_on <= 1'b0;
            if (r_take) begin
                rptr <= rptr + 1'b1;
                beat <= beat + 1'b1;
                if (beat == exp_len) rd_act <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_rdata: assert property (@(posedge aclk) disable iff (!rst_n)
        r_take |-> r.data === exp_data)
        else fail_run($sformatf("Mismatch at %0t: r.data got %h expected %h",
            $time, $sampled(r.data), $sampled(exp_data)));
    a_rid: assert property (@(posedge aclk) disable iff (!rst_n)
        r_take |-> r.id == exp_rid)
        else fail_run($sformatf("Mismatch at %0t: r.id got %h expected %h",
            $time, $sampled(r.id), $sampled(exp_rid)));
    a_rlast: assert property (@(posedge aclk) disable iff (!rst_n)
        r_take |-> r.last == (beat == exp_len))
        else fail_run($sformatf("Mismatch at %0t: r.last got %b expected %b",
            $time, $sampled(r.last), $sampled(beat == exp_len)));
    a_rresp: assert property (@(posedge aclk) disable iff (!rst_n)
        r_valid |-> r.resp == RESP_OKAY)
        else fail_run($sformatf("Mismatch at %0t: r.resp got %h expected %h",
            $time, $sampled(r.resp), RESP_OKAY));
    a_bresp: assert property (@(posedge aclk) disable iff (!rst_n)
        b_valid |-> b.id == exp_bid && b.resp == RESP_OKAY)
        else fail_run($sformatf("Mismatch at %0t: b got %h expected %h",
            $time, $sampled(b), {exp_bid, RESP_OKAY}));
    a_wlat: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(b_valid) |-> w_lat == W_DELAY)
        else fail_run($sformatf("Mismatch at %0t: write latency got %0d expected %0d",
            $time, $sampled(w_lat), W_DELAY));
    a_rlat: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(r_valid) |-> r_lat == R_DELAY)
        else fail_run($sformatf("Mismatch at %0t: read latency got %0d expected %0d",
            $time, $sampled(r_lat), R_DELAY));
    a_rhold: assert property (@(posedge aclk) disable iff (!rst_n)
        r_valid && !r_take |=> r_valid && $stable(r))
        else fail_run("read beat changed or dropped while not accepted");
    a_bhold: assert property (@(posedge aclk) disable iff (!rst_n)
        b_valid && !(b_ready && !stall) |=> b_valid && $stable(b))
        else fail_run("write response changed or dropped while not accepted");
    a_stall: assert property (@(posedge aclk) disable iff (!rst_n)
        stall |-> !aw_ready && !w_ready && !ar_ready)
        else fail_run("a ready was high during stall");
    a_down: assert property (@(posedge aclk) disable iff (!rst_n)
        down_stat |-> !up_stat && !aw_ready && !ar_ready && !rd_act && !wr_act)
        else fail_run("model down with traffic pending or address channel open");
    a_seq_start: assert property (@(posedge aclk) disable iff (!rst_n)
        $fell(dut_rst_n) |=> stall_gen)
        else fail_run("stall_gen did not rise on device reset");
    a_seq_end: assert property (@(posedge aclk) disable iff (!rst_n)
        $fell(stall_gen) |-> dut_rst_n)
        else fail_run("stall_gen fell while device still in reset");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                               input logic full, input int stall_n);
        int n;
        aw = '{id: ID_W'($random(seed)), addr: addr, len: len, size: 3'd3, burst: 2'b01};
        aw_valid = 1'b1;
        n = 0;
        while (!aw_ready) begin
            tick();
            n++;
            if (n > LIMIT) fail_run("timeout waiting for aw_ready");
        end
        tick();
        aw_valid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            w.data  = {$random(seed), $random(seed)};
            w.strb  = full ? '1 : STRB_W'($random(seed));   // partial lanes
            w.last  = (i == len);
            w_valid = 1'b1;
            if (!full && i == 1) begin
                stall = 1'b1;                       // beat waits out a stalled cycle
                tick();
                stall = 1'b0;
            end
            n = 0;
            while (!w_ready) begin
                tick();
                n++;
                if (n > LIMIT) fail_run("timeout waiting for w_ready");
            end
            tick();
        end
        w_valid = 1'b0;
        stall = (stall_n > 0);
        repeat (stall_n) tick();
        stall = 1'b0;
        n = 0;
        while (!b_valid) begin
            tick();
            n++;
            if (n > LIMIT) fail_run("timeout waiting for b_valid");
        end
        if (!full) begin
            b_ready = 1'b0;                         // response back-pressure
            tick();
            b_ready = 1'b1;
            stall   = 1'b1;                         // then a stalled cycle
            tick();
            stall   = 1'b0;
        end
        tick();
    endtask

    task automatic write_pair(input logic [ADDR_W-1:0] addr, input logic [7:0] len);
        write_burst(addr, len, 1'b1, 0);
        write_burst(addr, len, 1'b0, 2);
    endtask

    task automatic start_read(input logic [ADDR_W-1:0] addr, input logic [7:0] len,
                              input int stall_n);
        int n;
        ar = '{id: ID_W'($random(seed)), addr: addr, len: len, size: 3'd3, burst: 2'b01};
        ar_valid = 1'b1;
        n = 0;
        while (!ar_ready) begin
            tick();
            n++;
            if (n > LIMIT) fail_run("timeout waiting for ar_ready");
        end
        tick();
        ar_valid = 1'b0;
        tick();
        stall = (stall_n > 0);                      // delays first beat
        repeat (stall_n) tick();
        stall = 1'b0;
    endtask

    task automatic finish_read();
        int n;
        n = 0;
        while (rd_act) begin
            r_ready = 1'($random(seed));
            stall   = (($random(seed) & 3) == 0);
            tick();
            n++;
            if (n > LIMIT) fail_run("timeout waiting for read burst to finish");
        end
        r_ready = 1'b1;
        stall   = 1'b0;
    endtask

    task automatic wait_state(input logic want_up);
        int n;
        n = 0;
        while (want_up ? !(up_stat && !stall_gen) : !down_stat) begin
            tick();
            n++;
            if (n > LIMIT) fail_run("timeout waiting for model state change");
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] base0;
        logic [ADDR_W-1:0] base1;
        int n;
        seed = 32'hd9289964;
        rst_n = 1'b0;
        dut_rst_n = 1'b1;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        b_ready = 1'b1;
        ar = '0;
        ar_valid = 1'b0;
        r_ready = 1'b1;
        stall = 1'b0;
        up_req = 1'b0;
        down_req = 1'b0;
        repeat (3) tick();
        rst_n = 1'b1;
        tick();

        base0 = $random(seed) & 32'h0000_0ff8;
        base1 = base0 + 32'h1000;
        write_pair(base0, 8'd7);                    // round trip, latency
        start_read(base0, 8'd7, 0);
        finish_read();
        write_pair(base1, 8'd3);                    // stalled read wait
        start_read(base1, 8'd3, 3);
        finish_read();

        start_read(base0, 8'd7, 0);                 // host down mid burst
        down_req = 1'b1;
        tick();
        down_req = 1'b0;
        finish_read();
        wait_state(1'b0);
        aw_valid = 1'b1;
        ar_valid = 1'b1;
        repeat (5) tick();
        aw_valid = 1'b0;
        ar_valid = 1'b0;
        up_req = 1'b1;
        tick();
        up_req = 1'b0;
        wait_state(1'b1);
        start_read(base1, 8'd3, 0);
        finish_read();

        dut_rst_n = 1'b0;                           // device reset sequence
        n = 0;
        while (!stall_gen) begin
            tick();
            n++;
            if (n > LIMIT) fail_run("timeout waiting for stall_gen");
        end
        wait_state(1'b0);
        repeat (8) tick();
        dut_rst_n = 1'b1;
        wait_state(1'b1);
        start_read(base0, 8'd7, 0);
        finish_read();

        repeat (5) tick();
        $display("all tests passed");
        $finish;
    end

endmodule

// File: build.f
src/axi_pkg.sv
src/model_pkg.sv
src/model_mem.sv
src/axi_write_path.sv
src/axi_read_path.sv
src/model_ctrl.sv
src/rst_down_gen.sv
src/ram_model.sv
sim/tb_ram_model.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ram_model
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f build.f
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
